//--- flist.f
logic/reel_types_pkg.sv
logic/wager_rules_pkg.sv
logic/spin_fsm.sv
logic/reel_timer.sv
logic/reel_bank.sv
logic/bet_counter.sv
logic/payout_calc.sv
logic/slot_machine_top.sv
test/slot_machine_tb.sv

//--- logic/bet_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bet_counter import reel_types_pkg::*, wager_rules_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic bet_up_key,
	input  logic bet_down_key,
	output bet_t bet
);

	logic [1:0] keys;
	logic [1:0] key_prev;
	logic       up_fall;
	logic       down_fall;

	// ----------------------------------------------------------------------
	// key edges
	// ----------------------------------------------------------------------
	assign keys = {bet_down_key, bet_up_key};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			key_prev <= 2'b11;
		end else begin
			key_prev <= keys;
		end
	end

	assign up_fall   = key_prev[0] & ~keys[0];
	assign down_fall = key_prev[1] & ~keys[1];

	// ----------------------------------------------------------------------
	// bet register
	// ----------------------------------------------------------------------
	// up has priority over down
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			bet <= BET_MIN;
		end else if (up_fall) begin
			if (bet < BET_MAX) begin
				bet <= bet + 1'b1;
			end else begin
				bet <= BET_MIN;
			end
		end else if (down_fall) begin
			// saturates at the minimum
			if (bet > BET_MIN) begin
				bet <= bet - 1'b1;
			end
		end
	end

	a_bet_range: assert property (@(posedge clk) disable iff (!rst)
		bet inside {[BET_MIN:BET_MAX]});

endmodule

`default_nettype wire

//--- logic/payout_calc.sv
`timescale 1ns/1ps
`default_nettype none

module payout_calc import reel_types_pkg::*, wager_rules_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    spinning,
	input  logic    settle,
	input  symbol_t reel_left,
	input  symbol_t reel_center,
	input  symbol_t reel_right,
	input  bet_t    bet,
	output logic    win,
	output payout_t payout
);

	logic    match;
	payout_t product;

	// ----------------------------------------------------------------------
	// win judgement
	// ----------------------------------------------------------------------
	assign match = (reel_left == reel_center) && (reel_center == reel_right);

	// any reel gives the symbol on a match, center is used
	assign product = payout_t'(bet) * payout_t'(symbol_mult(reel_center));

	// ----------------------------------------------------------------------
	// result registers
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			win    <= 1'b0;
			payout <= '0;
		end else if (spinning) begin
			win    <= 1'b0;
			payout <= '0;
		end else if (settle) begin
			win    <= match;
			payout <= match ? product : '0;
		end
	end

	// bet is never below one, so a win always pays
	a_pay_iff_win: assert property (@(posedge clk) disable iff (!rst)
		(payout != '0) == win);

endmodule

`default_nettype wire

//--- logic/reel_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reel_bank import reel_types_pkg::*; #(
	parameter rand_t SEED_LEFT   = 8'h5a,
	parameter rand_t SEED_CENTER = 8'hc3,
	parameter rand_t SEED_RIGHT  = 8'h1e
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    spinning,
	input  logic    tick_fast,
	input  logic    tick_mid,
	input  logic    tick_slow,
	output symbol_t reel_left,
	output symbol_t reel_center,
	output symbol_t reel_right
);

	// index 0 left, 1 center, 2 right
	localparam rand_t SEED [3] = '{SEED_LEFT, SEED_CENTER, SEED_RIGHT};

	rand_t      lfsr [3];
	symbol_t    reel [3];
	logic [2:0] load;

	// ----------------------------------------------------------------------
	// random sources
	// ----------------------------------------------------------------------
	// x^8 + x^6 + x^5 + x^4 + 1, period 255
	function automatic rand_t lfsr_next(input rand_t cur);
		logic fb;
		fb = cur[7] ^ cur[5] ^ cur[4] ^ cur[3];
		return {cur[6:0], fb};
	endfunction

	assign load = {tick_slow, tick_mid, tick_fast} & {3{spinning}};

	// ----------------------------------------------------------------------
	// reel registers
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 3; i++) begin
				lfsr[i] <= SEED[i];
				reel[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				lfsr[i] <= lfsr_next(lfsr[i]);
				if (load[i]) begin
					reel[i] <= lfsr[i][2:0];
				end
			end
		end
	end

	assign reel_left   = reel[0];
	assign reel_center = reel[1];
	assign reel_right  = reel[2];

	// reels are frozen between spins
	a_reels_hold: assert property (@(posedge clk) disable iff (!rst)
		!spinning |=> $stable({reel_left, reel_center, reel_right}));

endmodule

`default_nettype wire

//--- logic/reel_timer.sv
`timescale 1ns/1ps
`default_nettype none

module reel_timer #(
	parameter int         DIV_W         = 23,
	parameter int         TICK_BIT_FAST = 20,
	parameter int         TICK_BIT_MID  = 21,
	parameter int         TICK_BIT_SLOW = 22,
	parameter logic [7:0] STOP_TICKS    = 8'd20
) (
	input  logic clk,
	input  logic rst,
	input  logic spinning,
	output logic tick_fast,
	output logic tick_mid,
	output logic tick_slow,
	output logic spin_done
);

	logic [DIV_W-1:0] div;
	logic [2:0]       tap;
	logic [2:0]       tap_prev;
	logic [2:0]       ticks;
	logic [7:0]       stop_count;

	// ----------------------------------------------------------------------
	// divider and tick pulses
	// ----------------------------------------------------------------------
	// bit order is fast, mid, slow from lsb up
	assign tap = {div[TICK_BIT_SLOW], div[TICK_BIT_MID], div[TICK_BIT_FAST]};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			div      <= '0;
			tap_prev <= '0;
			ticks    <= '0;
		end else begin
			div      <= div + 1'b1;
			tap_prev <= tap;
			ticks    <= tap & ~tap_prev;
		end
	end

	assign tick_fast = ticks[0];
	assign tick_mid  = ticks[1];
	assign tick_slow = ticks[2];

	// ----------------------------------------------------------------------
	// stop counter
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			stop_count <= '0;
		end else if (!spinning) begin
			stop_count <= '0;
		end else if (tick_mid && (stop_count < STOP_TICKS)) begin
			stop_count <= stop_count + 8'd1;
		end
	end

	assign spin_done = (stop_count >= STOP_TICKS);

	// each tick is a single cycle pulse
	a_tick_single: assert property (@(posedge clk) disable iff (!rst)
		(ticks & $past(ticks)) == 3'b000);

endmodule

`default_nettype wire

//--- logic/reel_types_pkg.sv
`default_nettype none

package reel_types_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	localparam int SYMBOL_W = 3;
	localparam int RAND_W   = 8;
	localparam int BET_W    = 7;
	localparam int PAYOUT_W = 10;

	// ----------------------------------------------------------------------
	// vector types
	// ----------------------------------------------------------------------
	// one of eight reel faces
	typedef logic [SYMBOL_W-1:0] symbol_t;

	// lfsr state word
	typedef logic [RAND_W-1:0]   rand_t;

	typedef logic [BET_W-1:0]    bet_t;

	// 100 x 10 = 1000 still fits in ten bits
	typedef logic [PAYOUT_W-1:0] payout_t;

endpackage

`default_nettype wire

//--- logic/slot_machine_top.sv
`timescale 1ns/1ps
`default_nettype none

module slot_machine_top import reel_types_pkg::*; #(
	parameter int         DIV_W         = 23,
	parameter int         TICK_BIT_FAST = 20,
	parameter int         TICK_BIT_MID  = 21,
	parameter int         TICK_BIT_SLOW = 22,
	parameter logic [7:0] STOP_TICKS    = 8'd20,
	parameter rand_t      SEED_LEFT     = 8'h5a,
	parameter rand_t      SEED_CENTER   = 8'hc3,
	parameter rand_t      SEED_RIGHT    = 8'h1e
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    spin_key,
	input  logic    bet_up_key,
	input  logic    bet_down_key,
	output logic    spinning,
	output logic    win,
	output symbol_t reel_left,
	output symbol_t reel_center,
	output symbol_t reel_right,
	output bet_t    bet,
	output payout_t payout
);

	logic tick_fast;
	logic tick_mid;
	logic tick_slow;
	logic spin_done;
	logic settle;

	// ----------------------------------------------------------------------
	// spin control
	// ----------------------------------------------------------------------
	spin_fsm u_spin_fsm (
		.clk       (clk),
		.rst       (rst),
		.spin_key  (spin_key),
		.spin_done (spin_done),
		.spinning  (spinning),
		.settle    (settle)
	);

	reel_timer #(
		.DIV_W         (DIV_W),
		.TICK_BIT_FAST (TICK_BIT_FAST),
		.TICK_BIT_MID  (TICK_BIT_MID),
		.TICK_BIT_SLOW (TICK_BIT_SLOW),
		.STOP_TICKS    (STOP_TICKS)
	) u_reel_timer (
		.clk       (clk),
		.rst       (rst),
		.spinning  (spinning),
		.tick_fast (tick_fast),
		.tick_mid  (tick_mid),
		.tick_slow (tick_slow),
		.spin_done (spin_done)
	);

	// ----------------------------------------------------------------------
	// reels, wager and result
	// ----------------------------------------------------------------------
	reel_bank #(
		.SEED_LEFT   (SEED_LEFT),
		.SEED_CENTER (SEED_CENTER),
		.SEED_RIGHT  (SEED_RIGHT)
	) u_reel_bank (
		.clk         (clk),
		.rst         (rst),
		.spinning    (spinning),
		.tick_fast   (tick_fast),
		.tick_mid    (tick_mid),
		.tick_slow   (tick_slow),
		.reel_left   (reel_left),
		.reel_center (reel_center),
		.reel_right  (reel_right)
	);

	bet_counter u_bet_counter (
		.clk          (clk),
		.rst          (rst),
		.bet_up_key   (bet_up_key),
		.bet_down_key (bet_down_key),
		.bet          (bet)
	);

	payout_calc u_payout_calc (
		.clk         (clk),
		.rst         (rst),
		.spinning    (spinning),
		.settle      (settle),
		.reel_left   (reel_left),
		.reel_center (reel_center),
		.reel_right  (reel_right),
		.bet         (bet),
		.win         (win),
		.payout      (payout)
	);

endmodule

`default_nettype wire

//--- logic/spin_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module spin_fsm (
	input  logic clk,
	input  logic rst,
	input  logic spin_key,
	input  logic spin_done,
	output logic spinning,
	output logic settle
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_SPIN,
		S_SETTLED
	} state_t;

	state_t state;
	logic   key_prev;
	logic   key_fall;

	// ----------------------------------------------------------------------
	// spin key edge
	// ----------------------------------------------------------------------
	// key idles high, so the previous sample resets high
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			key_prev <= 1'b1;
		end else begin
			key_prev <= spin_key;
		end
	end

	assign key_fall = key_prev & ~spin_key;

	// ----------------------------------------------------------------------
	// state machine
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= S_IDLE;
			spinning <= 1'b0;
			settle   <= 1'b0;
		end else begin
			settle <= 1'b0;
			case (state)
				S_IDLE, S_SETTLED: begin
					if (key_fall) begin
						state    <= S_SPIN;
						spinning <= 1'b1;
					end
				end
				S_SPIN: begin
					// key presses are ignored until the reels stop
					if (spin_done) begin
						state    <= S_SETTLED;
						spinning <= 1'b0;
						settle   <= 1'b1;
					end
				end
				default: begin
					state    <= S_IDLE;
					spinning <= 1'b0;
				end
			endcase
		end
	end

	// settle is the cycle right after the reels have stopped
	a_settle_apart: assert property (@(posedge clk) disable iff (!rst)
		!(spinning && settle));

endmodule

`default_nettype wire

//--- logic/wager_rules_pkg.sv
`default_nettype none

package wager_rules_pkg;

	import reel_types_pkg::*;

	// ----------------------------------------------------------------------
	// bet range
	// ----------------------------------------------------------------------
	localparam bet_t BET_MIN = bet_t'(1);
	localparam bet_t BET_MAX = bet_t'(100);

	// ----------------------------------------------------------------------
	// payout factors
	// ----------------------------------------------------------------------
	localparam logic [3:0] MULT_LOW  = 4'd2;
	localparam logic [3:0] MULT_MID  = 4'd5;
	localparam logic [3:0] MULT_HIGH = 4'd10;

	// symbol 3 is the jackpot face
	function automatic logic [3:0] symbol_mult(input symbol_t sym);
		logic [3:0] mult;
		case (sym)
			3'd0, 3'd2, 3'd5: mult = MULT_MID;
			3'd3:             mult = MULT_HIGH;
			default:          mult = MULT_LOW;
		endcase
		return mult;
	endfunction

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile and run the slot machine testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module slot_machine_tb \
	-f flist.f -o slot_machine_sim \
	&& ./obj_dir/slot_machine_sim \
	|| exit 1

//--- test/slot_machine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module slot_machine_tb import reel_types_pkg::*, wager_rules_pkg::*; ();

	localparam int         CLK_PERIOD   = 10;
	localparam int         ROUNDS       = 600;
	localparam int         TICK_BIT_MID = 3;
	localparam logic [7:0] STOP_TICKS   = 8'd4;

	// longest spin allowed by the timing rules
	localparam int MAX_SPIN = (int'(STOP_TICKS) + 1) * (2 ** (TICK_BIT_MID + 1)) + 3;
	// bet presses, both spin presses, the spin itself and the gap
	localparam int ROUND_CYCLES = 7 * 5 + 4 + 8 + MAX_SPIN + 4;
	localparam int WATCHDOG_NS  = 2 * (8 + ROUNDS * ROUND_CYCLES) * CLK_PERIOD;

	// payout factor per symbol index
	localparam int FACTOR [8] = '{MULT_MID, MULT_LOW, MULT_MID, MULT_HIGH,
		MULT_LOW, MULT_MID, MULT_LOW, MULT_LOW};

	logic    clk;
	logic    rst;
	logic    spin_key;
	logic    bet_up_key;
	logic    bet_down_key;
	logic    spinning;
	logic    win;
	symbol_t reel_left;
	symbol_t reel_center;
	symbol_t reel_right;
	bet_t    bet;
	payout_t payout;

	bet_t       model_bet;
	logic       up_prev;
	logic       down_prev;
	logic       spin_prev;
	logic       spin_d;
	logic       up_fall;
	logic       down_fall;
	logic       settle_seen;
	int         spin_len;
	logic       check_due;
	logic       exp_win;
	int         exp_pay;
	int         win_count;
	int         loss_count;
	logic [7:0] left_seen;
	logic [7:0] center_seen;
	logic [7:0] right_seen;

	slot_machine_top #(
		.DIV_W         (5),
		.TICK_BIT_FAST (2),
		.TICK_BIT_MID  (TICK_BIT_MID),
		.TICK_BIT_SLOW (4),
		.STOP_TICKS    (STOP_TICKS)
	) uut (
		.clk          (clk),
		.rst          (rst),
		.spin_key     (spin_key),
		.bet_up_key   (bet_up_key),
		.bet_down_key (bet_down_key),
		.spinning     (spinning),
		.win          (win),
		.reel_left    (reel_left),
		.reel_center  (reel_center),
		.reel_right   (reel_right),
		.bet          (bet),
		.payout       (payout)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ----------------------------------------------------------------------
	// failure reporting
	// ----------------------------------------------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_mismatch(input string name, input int exp, input int act);
		fail_run($sformatf("MISMATCH time=%0t signal=%s expected=%0d actual=%0d",
			$time, name, exp, act));
	endtask

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	assign up_fall     = up_prev & ~bet_up_key;
	assign down_fall   = down_prev & ~bet_down_key;
	assign settle_seen = spin_d & ~spinning;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			up_prev   <= 1'b1;
			down_prev <= 1'b1;
			spin_prev <= 1'b1;
			spin_d    <= 1'b0;
			spin_len  <= 0;
			model_bet <= BET_MIN;
		end else begin
			up_prev   <= bet_up_key;
			down_prev <= bet_down_key;
			spin_prev <= spin_key;
			spin_d    <= spinning;
			spin_len  <= spinning ? spin_len + 1 : 0;
			// up wins over down, wraps at the top, saturates at the bottom
			if (up_fall) begin
				model_bet <= (model_bet == BET_MAX) ? BET_MIN : bet_t'(model_bet + 1);
			end else if (down_fall && model_bet != BET_MIN) begin
				model_bet <= bet_t'(model_bet - 1);
			end
		end
	end

	// result expected on the edge after settle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			check_due   <= 1'b0;
			exp_win     <= 1'b0;
			exp_pay     <= 0;
			win_count   <= 0;
			loss_count  <= 0;
			left_seen   <= '0;
			center_seen <= '0;
			right_seen  <= '0;
		end else begin
			check_due <= settle_seen;
			if (settle_seen) begin
				exp_win <= (reel_left == reel_center) && (reel_left == reel_right);
				exp_pay <= ((reel_left == reel_center) && (reel_left == reel_right)) ?
					int'(model_bet) * FACTOR[reel_center] : 0;
				if ((reel_left == reel_center) && (reel_left == reel_right)) begin
					win_count <= win_count + 1;
				end else begin
					loss_count <= loss_count + 1;
				end
				left_seen[reel_left]     <= 1'b1;
				center_seen[reel_center] <= 1'b1;
				right_seen[reel_right]   <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	a_rst_spinning: assert property (@(posedge clk) $rose(rst) |-> !spinning)
		else report_mismatch("spinning", 0, int'($sampled(spinning)));
	a_rst_win: assert property (@(posedge clk) $rose(rst) |-> !win)
		else report_mismatch("win", 0, int'($sampled(win)));
	a_rst_payout: assert property (@(posedge clk) $rose(rst) |-> payout == '0)
		else report_mismatch("payout", 0, int'($sampled(payout)));
	a_rst_bet: assert property (@(posedge clk) $rose(rst) |-> bet == BET_MIN)
		else report_mismatch("bet", int'(BET_MIN), int'($sampled(bet)));
	a_rst_left: assert property (@(posedge clk) $rose(rst) |-> reel_left == '0)
		else report_mismatch("reel_left", 0, int'($sampled(reel_left)));
	a_rst_center: assert property (@(posedge clk) $rose(rst) |-> reel_center == '0)
		else report_mismatch("reel_center", 0, int'($sampled(reel_center)));
	a_rst_right: assert property (@(posedge clk) $rose(rst) |-> reel_right == '0)
		else report_mismatch("reel_right", 0, int'($sampled(reel_right)));

	a_bet_model: assert property (@(posedge clk) disable iff (!rst) bet == model_bet)
		else report_mismatch("bet", int'($sampled(model_bet)), int'($sampled(bet)));

	// a key edge while idle starts a spin, while spinning it is ignored
	a_spin_start: assert property (@(posedge clk) disable iff (!rst)
		(spin_prev && !spin_key && !spinning) |=> spinning)
		else report_mismatch("spinning", 1, int'($sampled(spinning)));
	a_spin_ignore: assert property (@(posedge clk) disable iff (!rst)
		(spin_prev && !spin_key && spinning) |=> spinning)
		else report_mismatch("spinning", 1, int'($sampled(spinning)));
	a_spin_bound: assert property (@(posedge clk) disable iff (!rst) spin_len <= MAX_SPIN)
		else fail_run("a spin lasted longer than the allowed number of cycles");
	a_reel_hold: assert property (@(posedge clk) disable iff (!rst)
		!spinning |=> $stable({reel_left, reel_center, reel_right}))
		else fail_run("a reel changed while the machine was not spinning");

	a_result_win: assert property (@(posedge clk) disable iff (!rst)
		check_due |-> win == exp_win)
		else report_mismatch("win", int'($sampled(exp_win)), int'($sampled(win)));
	a_result_pay: assert property (@(posedge clk) disable iff (!rst)
		check_due |-> int'(payout) == exp_pay)
		else report_mismatch("payout", $sampled(exp_pay), int'($sampled(payout)));
	a_clear_win: assert property (@(posedge clk) disable iff (!rst) spinning |=> !win)
		else report_mismatch("win", 0, int'($sampled(win)));
	a_clear_pay: assert property (@(posedge clk) disable iff (!rst)
		spinning |=> payout == '0)
		else report_mismatch("payout", 0, int'($sampled(payout)));

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	// kind 0 is up, 1 is down, 2 is both at once
	task automatic press_bet_keys(input int kind, input int hold);
		@(posedge clk);
		bet_up_key   <= (kind == 1);
		bet_down_key <= (kind == 0);
		repeat (hold) @(posedge clk);
		bet_up_key   <= 1'b1;
		bet_down_key <= 1'b1;
	endtask

	task automatic press_spin_key(input int hold);
		@(posedge clk);
		spin_key <= 1'b0;
		repeat (hold) @(posedge clk);
		spin_key <= 1'b1;
	endtask

	initial begin
		int presses;
		int pick;

		rst          = 1'b0;
		spin_key     = 1'b1;
		bet_up_key   = 1'b1;
		bet_down_key = 1'b1;
		void'($urandom(32'hdadc));
		repeat (8) @(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);

		for (int round = 0; round < ROUNDS; round++) begin
			presses = $urandom_range(0, 7);
			for (int p = 0; p < presses; p++) begin
				pick = $urandom_range(0, 19);
				// biased upward so the bet reaches the wrap point
				press_bet_keys((pick < 12) ? 0 : ((pick < 17) ? 1 : 2), $urandom_range(1, 3));
			end
			press_spin_key($urandom_range(1, 3));
			while (!spinning) @(posedge clk);
			// early second press, well before the shortest spin ends
			if ($urandom_range(0, 2) == 0) begin
				repeat ($urandom_range(1, 4)) @(posedge clk);
				press_spin_key($urandom_range(1, 2));
			end
			while (spinning) @(posedge clk);
			repeat (2) @(posedge clk);
		end
		repeat (4) @(posedge clk);

		if (win_count > 0 && loss_count > 0 && $countones(left_seen) >= 2 &&
			$countones(center_seen) >= 2 && $countones(right_seen) >= 2) begin
			$display("TEST PASS");
			$finish;
		end else begin
			fail_run("coverage of the outcomes was not reached, wins, losses or reel symbols");
		end
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		fail_run("timeout, the run did not finish in the expected time");
	end

endmodule

`default_nettype wire
